// File: build.f
hdl/mp_arith_pkg.sv
hdl/apb_map_pkg.sv
hdl/ling_prefix_adder.sv
hdl/limb_counter.sv
hdl/mp_sequencer.sv
hdl/limb_datapath.sv
hdl/apb_mp_regs.sv
hdl/mp_adder_top.sv
sim/mp_adder_props.sv
sim/mp_adder_tb.sv

// File: build.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module mp_adder_tb -o mp_adder_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

out=$(./obj_dir/mp_adder_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1

// File: hdl/apb_map_pkg.sv
// APB widths, register map and control-word layout of the multi-precision adder
package apb_map_pkg;

	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// Single registers
	localparam logic [APB_AW-1:0] ADDR_CTRL = 8'h00;
	localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h04;

	// Limb files, one word per limb, 4 bytes apart
	localparam logic [APB_AW-1:0] ADDR_A_BASE = 8'h10;
	localparam logic [APB_AW-1:0] ADDR_B_BASE = 8'h20;
	localparam logic [APB_AW-1:0] ADDR_R_BASE = 8'h30;

	// Control word as bus data or as fields
	typedef union packed {
		logic [APB_DW-1:0] raw;
		struct packed {
			logic [APB_DW-mp_arith_pkg::IDX_W-3:0] reserved;
			logic [mp_arith_pkg::IDX_W-1:0] len_m1;
			logic sub;
			logic start;
		} fields;
	} ctrl_word_u;

endpackage

// File: hdl/apb_mp_regs.sv
// APB slave for control, status and limb access, stalled while an operation runs
`timescale 1ns/1ps

module apb_mp_regs (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [apb_map_pkg::APB_AW-1:0]  paddr,
	input  logic [apb_map_pkg::APB_DW-1:0]  pwdata,
	output logic [apb_map_pkg::APB_DW-1:0]  prdata,
	output logic                            pready,
	output logic                            pslverr,
	input  logic                            busy,
	input  logic                            done,
	input  logic                            carry_out,
	input  logic [mp_arith_pkg::LIMB_W-1:0] rd_limb,
	output logic                            start,
	output logic                            sub,
	output logic [mp_arith_pkg::IDX_W-1:0]  len_m1,
	output logic                            op_we_a,
	output logic                            op_we_b,
	output logic [mp_arith_pkg::IDX_W-1:0]  wr_idx,
	output logic [mp_arith_pkg::LIMB_W-1:0] wr_limb,
	output logic [mp_arith_pkg::IDX_W+1:0]  rd_idx
);
	import mp_arith_pkg::*;
	import apb_map_pkg::*;

	ctrl_word_u ctrl_q;
	ctrl_word_u wr_word;
	logic word_ok;
	logic hit_ctrl;
	logic hit_status;
	logic hit_a;
	logic hit_b;
	logic hit_r;
	logic err;
	logic access;
	logic wr_ok;

	assign wr_word = pwdata;

	// Limb files decode on the upper address bits
	assign word_ok = (paddr[1:0] == 2'b00);
	assign hit_ctrl = (paddr == ADDR_CTRL);
	assign hit_status = (paddr == ADDR_STATUS);
	assign hit_a = word_ok && (paddr[APB_AW-1:IDX_W+2] == ADDR_A_BASE[APB_AW-1:IDX_W+2]);
	assign hit_b = word_ok && (paddr[APB_AW-1:IDX_W+2] == ADDR_B_BASE[APB_AW-1:IDX_W+2]);
	assign hit_r = word_ok && (paddr[APB_AW-1:IDX_W+2] == ADDR_R_BASE[APB_AW-1:IDX_W+2]);

	assign err = !(hit_ctrl || hit_status || hit_a || hit_b || hit_r) ||
		(pwrite && (hit_status || hit_r));

	// No wait states unless busy
	assign pready = !busy;
	assign access = psel && penable && pready;
	assign pslverr = access && err;
	assign wr_ok = access && pwrite && !err;

	assign op_we_a = wr_ok && hit_a;
	assign op_we_b = wr_ok && hit_b;
	assign wr_idx = paddr[IDX_W+1:2];
	assign wr_limb = pwdata[LIMB_W-1:0];
	assign rd_idx = paddr[IDX_W+3:2];

	// Counter takes the length straight off the start write
	assign start = wr_ok && hit_ctrl && wr_word.fields.start;
	assign len_m1 = wr_word.fields.len_m1;
	assign sub = ctrl_q.fields.sub;

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_q <= '0;
		end else if (wr_ok && hit_ctrl) begin
			ctrl_q.fields.len_m1 <= wr_word.fields.len_m1;
			ctrl_q.fields.sub <= wr_word.fields.sub;
		end
	end

	always_comb begin
		prdata = '0;
		if (hit_ctrl) begin
			prdata = ctrl_q.raw;
		end else if (hit_status) begin
			prdata = {{(APB_DW-3){1'b0}}, carry_out, done, busy};
		end else if (hit_a || hit_b || hit_r) begin
			prdata = {{(APB_DW-LIMB_W){1'b0}}, rd_limb};
		end
	end

endmodule

// File: hdl/limb_counter.sv
// Limb index counter that holds the operation length and flags the last limb
`timescale 1ns/1ps

module limb_counter (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           load,
	input  logic                           en,
	input  logic [mp_arith_pkg::IDX_W-1:0] len_m1,
	output logic [mp_arith_pkg::IDX_W-1:0] idx,
	output logic                           last
);
	import mp_arith_pkg::*;

	logic [IDX_W-1:0] len_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			idx <= '0;
			len_q <= '0;
		end else if (load) begin
			idx <= '0;
			len_q <= len_m1;
		end else if (en) begin
			idx <= idx + 1'b1;
		end
	end

	assign last = (idx == len_q);

endmodule

// File: hdl/limb_datapath.sv
// Operand and result limb files with carry-chained add or subtract per step
`timescale 1ns/1ps

module limb_datapath (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            op_we_a,
	input  logic                            op_we_b,
	input  logic [mp_arith_pkg::IDX_W-1:0]  wr_idx,
	input  logic [mp_arith_pkg::LIMB_W-1:0] wr_limb,
	input  logic [mp_arith_pkg::IDX_W+1:0]  rd_idx,
	input  logic                            step,
	input  logic                            first,
	input  logic [mp_arith_pkg::IDX_W-1:0]  idx,
	input  logic                            sub,
	input  logic                            start,
	output logic [mp_arith_pkg::LIMB_W-1:0] rd_limb,
	output logic                            carry_out
);
	import mp_arith_pkg::*;

	logic [LIMB_W-1:0] a_mem [0:LIMB_N-1];
	logic [LIMB_W-1:0] b_mem [0:LIMB_N-1];
	logic [LIMB_W-1:0] r_mem [0:LIMB_N-1];
	logic [LIMB_W-1:0] b_op;
	logic [LIMB_W-1:0] sum;
	logic cin;
	logic cout;
	logic carry_q;

	// Subtract is A + ~B + 1
	assign b_op = (sub == OP_SUB) ? ~b_mem[idx] : b_mem[idx];
	assign cin = first ? (sub != OP_ADD) : carry_q;

	ling_prefix_adder u_adder (
		.a    (a_mem[idx]),
		.b    (b_op),
		.cin  (cin),
		.sum  (sum),
		.cout (cout)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < LIMB_N; i++) begin
				a_mem[i] <= '0;
				b_mem[i] <= '0;
				r_mem[i] <= '0;
			end
			carry_q <= 1'b0;
		end else begin
			if (op_we_a) begin
				a_mem[wr_idx] <= wr_limb;
			end
			if (op_we_b) begin
				b_mem[wr_idx] <= wr_limb;
			end
			if (start) begin
				for (int i = 0; i < LIMB_N; i++) begin
					r_mem[i] <= '0;
				end
				carry_q <= 1'b0;
			end else if (step) begin
				r_mem[idx] <= sum;
				carry_q <= cout;
			end
		end
	end

	// Upper index bits select the file, 1 A, 2 B, 3 result
	always_comb begin
		case (rd_idx[IDX_W+1:IDX_W])
			2'd1: rd_limb = a_mem[rd_idx[IDX_W-1:0]];
			2'd2: rd_limb = b_mem[rd_idx[IDX_W-1:0]];
			2'd3: rd_limb = r_mem[rd_idx[IDX_W-1:0]];
			default: rd_limb = '0;
		endcase
	end

	assign carry_out = carry_q;

endmodule

// File: hdl/ling_prefix_adder.sv
// Ling pseudo-carry parallel-prefix adder for one limb with carry in and out
`timescale 1ns/1ps

module ling_prefix_adder (
	input  logic [mp_arith_pkg::LIMB_W-1:0] a,
	input  logic [mp_arith_pkg::LIMB_W-1:0] b,
	input  logic                            cin,
	output logic [mp_arith_pkg::LIMB_W-1:0] sum,
	output logic                            cout
);
	import mp_arith_pkg::*;

	// Bit 0 of g is the carry in, operand bits sit at 1 and up
	logic [LIMB_W:1] p;
	logic [LIMB_W:0] g;
	logic [LIMB_W:1] h;
	logic [LIMB_W:1] c;

	// Pseudo-carry and group propagate of odd bit 2m+1, per tree level
	logic hh [0:PFX_LEVELS][0:PFX_NODES-1];
	logic ii [0:PFX_LEVELS][0:PFX_NODES-1];

	genvar m;
	genvar l;

	assign p = a | b;
	assign g = {a & b, cin};

	generate
		// Reduced cells on bit pairs
		for (m = 0; m < PFX_NODES; m++) begin : g_pair
			assign hh[0][m] = g[2*m+1] | g[2*m];
			if (m == 0) begin : g_head
				assign ii[0][m] = 1'b0;
			end else begin : g_body
				assign ii[0][m] = p[2*m] & p[2*m-1];
			end
		end

		// Sparse tree, span doubles every level
		for (l = 1; l <= PFX_LEVELS; l++) begin : g_level
			for (m = 0; m < PFX_NODES; m++) begin : g_node
				if (m < 2**(l-1)) begin : g_done
					assign hh[l][m] = hh[l-1][m];
					assign ii[l][m] = 1'b0;
				end else if (m < 2**l) begin : g_grey
					// Lower group already reaches bit 0
					assign hh[l][m] = hh[l-1][m] | (ii[l-1][m] & hh[l-1][m-2**(l-1)]);
					assign ii[l][m] = 1'b0;
				end else begin : g_black
					assign hh[l][m] = hh[l-1][m] | (ii[l-1][m] & hh[l-1][m-2**(l-1)]);
					assign ii[l][m] = ii[l-1][m] & ii[l-1][m-2**(l-1)];
				end
			end
		end

		// Odd bits straight from the tree, even bits through one more grey cell
		for (m = 1; m <= PFX_NODES; m++) begin : g_even
			assign h[2*m-1] = hh[PFX_LEVELS][m-1];
			assign h[2*m] = g[2*m] | (p[2*m-1] & hh[PFX_LEVELS][m-1]);
		end
	endgenerate

	// Real carry into each bit is p of the bit below and its H
	assign c = {p[LIMB_W-1:1] & h[LIMB_W-1:1], g[0]};

	assign sum = (p ^ h) | (g[LIMB_W:1] & c);
	assign cout = p[LIMB_W] & h[LIMB_W];

endmodule

// File: hdl/mp_adder_top.sv
// Multi-precision add and subtract peripheral on APB
`timescale 1ns/1ps

module mp_adder_top (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [apb_map_pkg::APB_AW-1:0] paddr,
	input  logic [apb_map_pkg::APB_DW-1:0] pwdata,
	output logic [apb_map_pkg::APB_DW-1:0] prdata,
	output logic                           pready,
	output logic                           pslverr
);
	import mp_arith_pkg::*;

	logic start;
	logic sub;
	logic [IDX_W-1:0] len_m1;
	logic op_we_a;
	logic op_we_b;
	logic [IDX_W-1:0] wr_idx;
	logic [LIMB_W-1:0] wr_limb;
	logic [IDX_W+1:0] rd_idx;
	logic [LIMB_W-1:0] rd_limb;
	logic busy;
	logic done;
	logic carry_out;
	logic cnt_load;
	logic cnt_en;
	logic step;
	logic first;
	logic [IDX_W-1:0] idx;
	logic last;

	apb_mp_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.busy      (busy),
		.done      (done),
		.carry_out (carry_out),
		.rd_limb   (rd_limb),
		.start     (start),
		.sub       (sub),
		.len_m1    (len_m1),
		.op_we_a   (op_we_a),
		.op_we_b   (op_we_b),
		.wr_idx    (wr_idx),
		.wr_limb   (wr_limb),
		.rd_idx    (rd_idx)
	);

	mp_sequencer u_seq (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.last     (last),
		.cnt_load (cnt_load),
		.cnt_en   (cnt_en),
		.step     (step),
		.first    (first),
		.busy     (busy),
		.done     (done)
	);

	limb_counter u_cnt (
		.clk    (clk),
		.reset  (reset),
		.load   (cnt_load),
		.en     (cnt_en),
		.len_m1 (len_m1),
		.idx    (idx),
		.last   (last)
	);

	limb_datapath u_dp (
		.clk       (clk),
		.reset     (reset),
		.op_we_a   (op_we_a),
		.op_we_b   (op_we_b),
		.wr_idx    (wr_idx),
		.wr_limb   (wr_limb),
		.rd_idx    (rd_idx),
		.step      (step),
		.first     (first),
		.idx       (idx),
		.sub       (sub),
		.start     (start),
		.rd_limb   (rd_limb),
		.carry_out (carry_out)
	);

endmodule

// File: hdl/mp_arith_pkg.sv
// Limb geometry, opcodes and sequencer states of the multi-precision adder
package mp_arith_pkg;

	// Limb geometry
	localparam int LIMB_W = 28;
	localparam int LIMB_N = 4;
	localparam int IDX_W = 2;

	// Odd-bit nodes and log stages of the limb prefix tree
	localparam int PFX_NODES = LIMB_W / 2;
	localparam int PFX_LEVELS = $clog2(PFX_NODES);

	// Opcodes as carried in the sub bit
	localparam logic OP_ADD = 1'b0;
	localparam logic OP_SUB = 1'b1;

	// Sequencer state encoding
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_RUN = 2'd1;
	localparam logic [1:0] ST_FINISH = 2'd2;

endpackage

// File: hdl/mp_sequencer.sv
// Operation FSM that steps one limb per cycle and reports busy and done
`timescale 1ns/1ps

module mp_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic last,
	output logic cnt_load,
	output logic cnt_en,
	output logic step,
	output logic first,
	output logic busy,
	output logic done
);
	import mp_arith_pkg::*;

	logic [1:0] state;
	logic first_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			first_q <= 1'b0;
		end else begin
			case (state)
				ST_RUN: begin
					first_q <= 1'b0;
					if (last) begin
						state <= ST_FINISH;
					end
				end
				default: begin
					// IDLE and FINISH both wait for start
					if (start) begin
						state <= ST_RUN;
						first_q <= 1'b1;
					end
				end
			endcase
		end
	end

	assign busy = (state == ST_RUN);
	assign step = busy;
	assign cnt_en = busy;
	assign cnt_load = start && !busy;
	assign first = first_q;

	// Held in FINISH until the next start
	assign done = (state == ST_FINISH);

endmodule

// File: sim/mp_adder_props.sv
// Start, error response and busy length properties of the register block
`timescale 1ns/1ps

module mp_adder_props (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic pready,
	input logic pslverr,
	input logic busy
);
	import mp_arith_pkg::*;

	int busy_cycles;

	always_ff @(posedge clk) begin
		if (reset || !busy) begin
			busy_cycles <= 0;
		end else begin
			busy_cycles <= busy_cycles + 1;
		end
	end

	// An operation only starts from a completed, accepted write
	a_start_write: assert property (@(posedge clk) disable iff (reset)
		$rose(busy) |-> $past(psel && penable && pwrite && pready && !pslverr))
		else $error("busy rose without an accepted APB write");

	a_err_no_start: assert property (@(posedge clk) disable iff (reset)
		pslverr |=> !busy)
		else $error("a rejected access started an operation");

	a_busy_bound: assert property (@(posedge clk) disable iff (reset)
		busy_cycles <= LIMB_N + 1)
		else $error("busy held longer than one full operation");

endmodule

bind apb_mp_regs mp_adder_props u_props (.*);

// File: sim/mp_adder_tb.sv
// Testbench for the APB multi-precision adder with directed and random operations
`timescale 1ns/1ps

module mp_adder_tb;
	import mp_arith_pkg::*;
	import apb_map_pkg::*;

	localparam int PERIOD = 8;
	localparam int MAX_PAT = 32;
	localparam int N_RAND = 20;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;

	int cycles = 0;
	int limit = 100;
	int pat_count = 0;
	logic pat_op [0:MAX_PAT-1];
	int pat_len [0:MAX_PAT-1];
	logic [111:0] pat_a [0:MAX_PAT-1];
	logic [111:0] pat_b [0:MAX_PAT-1];
	logic [111:0] pat_r [0:MAX_PAT-1];
	logic pat_c [0:MAX_PAT-1];

	mp_adder_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("Timeout: the DUT stopped responding after %0d cycles", cycles);
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Sample 1 ns after the falling edge, where pready and prdata are settled
	task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
		input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		while (!pready) begin
			@(negedge clk);
			#1;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
		output logic err);
		logic [APB_DW-1:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
		output logic err);
		apb_access(1'b0, addr, '0, data, err);
	endtask

	task automatic check_limb(input string name, input logic [LIMB_W-1:0] exp,
		input logic [LIMB_W-1:0] act);
		if (act !== exp) begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_word(input string name, input logic [APB_DW-1:0] exp,
		input logic [APB_DW-1:0] act);
		if (act !== exp) begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	// Reference arithmetic over the active limbs only
	task automatic compute_expected(input logic op, input int len, input logic [111:0] a,
		input logic [111:0] b, output logic [111:0] r, output logic c);
		logic [112:0] mask;
		logic [112:0] aa;
		logic [112:0] bb;
		logic [112:0] full;
		mask = (113'd1 << (LIMB_W * len)) - 113'd1;
		aa = {1'b0, a} & mask;
		bb = {1'b0, b} & mask;
		if (op == OP_SUB) begin
			full = (aa - bb) & mask;
			c = (aa >= bb);
		end else begin
			full = aa + bb;
			c = full[LIMB_W * len];
			full = full & mask;
		end
		r = full[111:0];
	endtask

	task automatic run_op(input logic op, input int len, input logic [111:0] a,
		input logic [111:0] b, input logic [111:0] r, input logic c);
		logic [APB_DW-1:0] d;
		logic e;
		ctrl_word_u cw;
		for (int i = 0; i < LIMB_N; i++) begin
			apb_write(ADDR_A_BASE + 8'(4 * i), {4'h0, a[LIMB_W*i +: LIMB_W]}, e);
			check_err("pslverr on A write", 1'b0, e);
			apb_write(ADDR_B_BASE + 8'(4 * i), {4'h0, b[LIMB_W*i +: LIMB_W]}, e);
			check_err("pslverr on B write", 1'b0, e);
		end
		cw = '0;
		cw.fields.start = 1'b1;
		cw.fields.sub = op;
		cw.fields.len_m1 = 2'(len - 1);
		apb_write(ADDR_CTRL, cw.raw, e);
		check_err("pslverr on CTRL write", 1'b0, e);
		// Stalls until busy falls
		apb_read(ADDR_STATUS, d, e);
		check_word("status", {29'd0, c, 1'b1, 1'b0}, d);
		for (int i = 0; i < LIMB_N; i++) begin
			apb_read(ADDR_R_BASE + 8'(4 * i), d, e);
			check_word($sformatf("prdata upper bits of R[%0d]", i), 32'd0, d & 32'hF0000000);
			check_limb($sformatf("R[%0d]", i), r[LIMB_W*i +: LIMB_W], d[LIMB_W-1:0]);
		end
	endtask

	task automatic load_patterns();
		int fd;
		int n;
		int op_i;
		int len_i;
		int c_i;
		string line;
		logic [111:0] a;
		logic [111:0] b;
		logic [111:0] r;
		fd = $fopen("sim/mp_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file sim/mp_patterns.txt");
			$display("TESTS FAILED");
			$fatal(1);
		end
		while (!$feof(fd) && pat_count < MAX_PAT) begin
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#" &&
				$sscanf(line, "%d %d %h %h %h %d", op_i, len_i, a, b, r, c_i) == 6) begin
				pat_op[pat_count] = (op_i != 0);
				pat_len[pat_count] = len_i;
				pat_a[pat_count] = a;
				pat_b[pat_count] = b;
				pat_r[pat_count] = r;
				pat_c[pat_count] = (c_i != 0);
				pat_count++;
			end
		end
		$fclose(fd);
	endtask

	initial begin
		logic [APB_DW-1:0] d;
		logic e;
		logic [31:0] lcg;
		logic [111:0] ra;
		logic [111:0] rb;
		logic [111:0] rr;
		logic rc;
		logic rop;
		int rlen;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		load_patterns();
		if (pat_count == 0) begin
			$display("The pattern file holds no usable vectors");
			$display("TESTS FAILED");
			$fatal(1);
		end
		limit = (pat_count + N_RAND) * 60 + 100;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Reset values
		apb_read(ADDR_STATUS, d, e);
		check_err("pslverr on STATUS read", 1'b0, e);
		check_word("status after reset", 32'd0, d);
		for (int i = 0; i < 3 * LIMB_N; i++) begin
			apb_read(ADDR_A_BASE + 8'(4 * i), d, e);
			check_word($sformatf("limb word %0d after reset", i), 32'd0, d);
		end

		for (int p = 0; p < pat_count; p++) begin
			run_op(pat_op[p], pat_len[p], pat_a[p], pat_b[p], pat_r[p], pat_c[p]);
		end

		// Unmapped address, then a write to a result limb
		apb_read(8'h08, d, e);
		check_err("pslverr on unmapped read", 1'b1, e);
		apb_write(ADDR_R_BASE, 32'h0ABCDEF1, e);
		check_err("pslverr on R[0] write", 1'b1, e);
		apb_read(ADDR_R_BASE, d, e);
		check_limb("R[0] after rejected write", pat_r[pat_count-1][LIMB_W-1:0], d[LIMB_W-1:0]);

		lcg = 32'd58;
		for (int k = 0; k < N_RAND; k++) begin
			for (int i = 0; i < LIMB_N; i++) begin
				lcg = lcg_next(lcg);
				ra[LIMB_W*i +: LIMB_W] = lcg[31:4];
				lcg = lcg_next(lcg);
				rb[LIMB_W*i +: LIMB_W] = lcg[31:4];
			end
			lcg = lcg_next(lcg);
			rop = lcg[31];
			rlen = int'(lcg[30:29]) + 1;
			compute_expected(rop, rlen, ra, rb, rr, rc);
			run_op(rop, rlen, ra, rb, rr, rc);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: sim/mp_patterns.txt
# op (0 add, 1 sub) len A B expected_R expected_carry
# A, B and R are 112-bit hex with limb 3 leftmost, 7 digits per limb
0 1 000000000000000000000FFFFFFF 0000000000000000000000000001 0000000000000000000000000000 1
0 2 000000000000000000000FFFFFFF 0000000000000000000000000001 0000000000000000000010000000 0
0 4 FFFFFFFFFFFFFFFFFFFFFFFFFFFF 0000000000000000000000000001 0000000000000000000000000000 1
0 3 FFFFFFF123456789ABCDEF012345 FFFFFFF111111111111111111111 000000023456789ABCDF00123456 0
1 1 0000000000000000000000000005 0000000000000000000000000003 0000000000000000000000000002 1
1 1 0000000000000000000000000003 0000000000000000000000000005 000000000000000000000FFFFFFE 0
1 2 0000000000000000000010000000 0000000000000000000000000001 000000000000000000000FFFFFFF 1
1 4 ABCDEF012345670FEDCBA7654321 ABCDEF012345670FEDCBA7654321 0000000000000000000000000000 1
1 4 0000000000000000000000000000 0000000000000000000000000001 FFFFFFFFFFFFFFFFFFFFFFFFFFFF 0
0 4 8000000000000000000000000000 8000000000000000000000000000 0000000000000000000000000000 1
1 3 0000000000000000000000000009 FFFFFFF000000000000000000004 0000000000000000000000000005 1
